/* src/icache_cfg_pkg.sv */
package icache_cfg_pkg;

    // instruction and line geometry
    localparam int inst_width = 32;
    localparam int line_bytes = 64;
    localparam int mem_data_w = 128;
    localparam int transfers_per_line = line_bytes * 8 / mem_data_w;
    localparam int words_per_line = line_bytes * 8 / inst_width;

    localparam int sets = 2;
    localparam int ways = 2;

    // core word address splits into tag, set index and word offset
    localparam int core_addr_w = 7;
    localparam int off_w = $clog2(words_per_line);
    localparam int beat_w = $clog2(transfers_per_line);
    localparam int idx_w = $clog2(sets);
    localparam int tag_w = core_addr_w - idx_w - off_w;
    localparam int way_w = $clog2(ways);
    localparam int lru_max = ways - 1;

    // memory side addresses whole 128-bit words
    localparam int mem_addr_w = core_addr_w - off_w + beat_w;

    typedef enum logic [1:0] {
        ic_reset,
        ic_ready,
        ic_miss
    } icache_state_t;

endpackage

/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

    // queue depth inside the memory model
    localparam int mem_queue_depth = 2;

    // core side carries word addresses and single instructions
    typedef struct packed {
        logic [icache_cfg_pkg::core_addr_w-1:0] addr;
    } core_req_t;

    typedef struct packed {
        logic [icache_cfg_pkg::inst_width-1:0] data;
    } core_rsp_t;

    // memory side moves one 128-bit beat per transfer
    typedef struct packed {
        logic [icache_cfg_pkg::mem_addr_w-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [icache_cfg_pkg::mem_data_w-1:0] data;
    } mem_rsp_t;

endpackage

/* src/rv_fifo.sv */
`timescale 1ns/1ps

module rv_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         slots [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready = (count != cnt_w'(depth));
    assign out_valid = (count != '0);
    assign out_data = slots[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_data;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* src/icache_way_select.sv */
`timescale 1ns/1ps

module icache_way_select
    import icache_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [core_addr_w-1:0] lookup_addr,
    output logic                   hit,
    output logic [way_w-1:0]       hit_way,
    output logic [way_w-1:0]       victim_way,
    input  logic                   touch,
    input  logic [idx_w-1:0]       touch_set,
    input  logic [way_w-1:0]       touch_way,
    input  logic                   fill,
    input  logic [idx_w-1:0]       fill_set,
    input  logic [way_w-1:0]       fill_way,
    input  logic [tag_w-1:0]       fill_tag
);
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [way_w-1:0] lru;
    } line_meta_t;

    line_meta_t       meta_q [sets][ways];
    logic [idx_w-1:0] lookup_set;
    logic [tag_w-1:0] lookup_tag;

    assign lookup_set = lookup_addr[off_w +: idx_w];
    assign lookup_tag = lookup_addr[core_addr_w-1 -: tag_w];

    // compare all ways of the set and mark the oldest way as victim
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        victim_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (meta_q[lookup_set][w].valid && (meta_q[lookup_set][w].tag == lookup_tag)) begin
                hit = 1'b1;
                hit_way = way_w'(w);
            end
            if (meta_q[lookup_set][w].lru == way_w'(lru_max)) begin
                victim_way = way_w'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                for (int w = 0; w < ways; w++) begin
                    meta_q[s][w].valid <= 1'b0;
                    meta_q[s][w].lru <= way_w'(w);
                end
            end
        end else begin
            if (fill) begin
                meta_q[fill_set][fill_way].valid <= 1'b1;
                meta_q[fill_set][fill_way].tag <= fill_tag;
            end
            // counters stay a permutation so the increment never wraps
            if (touch) begin
                for (int w = 0; w < ways; w++) begin
                    if (meta_q[touch_set][w].lru < meta_q[touch_set][touch_way].lru) begin
                        meta_q[touch_set][w].lru <= meta_q[touch_set][w].lru + 1'b1;
                    end
                end
                meta_q[touch_set][touch_way].lru <= '0;
            end
        end
    end

endmodule

/* src/icache.sv */
`timescale 1ns/1ps

module icache
    import icache_cfg_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_core_valid,
    output logic      req_core_ready,
    input  core_req_t req_core,
    output logic      rsp_core_valid,
    output core_rsp_t rsp_core,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_req_t  mem_req,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,
    input  mem_rsp_t  mem_rsp
);
    // one line seen as memory beats or as instruction words
    typedef union packed {
        logic [transfers_per_line-1:0][mem_data_w-1:0] beat;
        logic [words_per_line-1:0][inst_width-1:0]     word;
    } line_data_t;

    typedef struct packed {
        logic                   active;
        logic [core_addr_w-1:0] addr;
        logic [way_w-1:0]       way;
    } pend_t;

    line_data_t        data_q [ways][sets];
    icache_state_t     state_q;
    icache_state_t     state_d;
    core_req_t         req_q;
    logic              req_vld_q;
    pend_t             pend_q;
    logic [beat_w:0]   issue_cnt;
    logic [beat_w-1:0] beat_cnt;
    logic              hit;
    logic [way_w-1:0]  hit_way;
    logic [way_w-1:0]  victim_way;
    logic [idx_w-1:0]  req_set;
    logic [idx_w-1:0]  pend_set;
    logic              save_pend;
    logic              serve_pend;
    logic              mem_req_fire;
    logic              mem_rsp_fire;
    logic              fill;

    assign req_set = req_q.addr[off_w +: idx_w];
    assign pend_set = pend_q.addr[off_w +: idx_w];
    assign mem_req_fire = mem_req_valid && mem_req_ready;
    assign mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;
    assign fill = mem_rsp_fire && (beat_cnt == beat_w'(transfers_per_line - 1));

    // lookup runs on the registered request in the response cycle
    icache_way_select way_sel_i (
        .clk        (clk),
        .rst        (rst),
        .lookup_addr(req_q.addr),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .touch      (rsp_core_valid),
        .touch_set  (serve_pend ? pend_set : req_set),
        .touch_way  (serve_pend ? pend_q.way : hit_way),
        .fill       (fill),
        .fill_set   (pend_set),
        .fill_way   (pend_q.way),
        .fill_tag   (pend_q.addr[core_addr_w-1 -: tag_w])
    );

    always_ff @(posedge clk) begin
        if (req_core_valid && req_core_ready) begin
            req_q <= req_core;
        end
        if (mem_rsp_fire) begin
            data_q[pend_q.way][pend_set].beat[beat_cnt] <= mem_rsp.data;
        end
        if (save_pend) begin
            pend_q.addr <= req_q.addr;
            pend_q.way <= victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ic_reset;
            req_vld_q <= 1'b0;
            pend_q.active <= 1'b0;
            issue_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            state_q <= state_d;
            req_vld_q <= req_core_valid && req_core_ready;
            if (save_pend) begin
                pend_q.active <= 1'b1;
            end else if (serve_pend) begin
                pend_q.active <= 1'b0;
            end
            // first beat may already be accepted in the miss cycle
            if (save_pend) begin
                issue_cnt <= {{beat_w{1'b0}}, mem_req_fire};
            end else if (mem_req_fire) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (mem_rsp_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ic_reset: state_d = ic_ready;
            ic_ready: begin
                if (save_pend) begin
                    state_d = ic_miss;
                end
            end
            ic_miss: begin
                if (fill) begin
                    state_d = ic_ready;
                end
            end
            default: state_d = ic_reset;
        endcase
    end

    always_comb begin
        req_core_ready = 1'b0;
        rsp_core_valid = 1'b0;
        rsp_core = '0;
        mem_req_valid = 1'b0;
        mem_req = '0;
        mem_rsp_ready = 1'b0;
        save_pend = 1'b0;
        serve_pend = 1'b0;
        case (state_q)
            ic_ready: begin
                req_core_ready = 1'b1;
                if (pend_q.active) begin
                    // answer the request that caused the fill
                    serve_pend = 1'b1;
                    rsp_core_valid = 1'b1;
                    rsp_core.data = data_q[pend_q.way][pend_set].word[pend_q.addr[off_w-1:0]];
                end else if (req_vld_q && hit) begin
                    rsp_core_valid = 1'b1;
                    rsp_core.data = data_q[hit_way][req_set].word[req_q.addr[off_w-1:0]];
                end else if (req_vld_q) begin
                    req_core_ready = 1'b0;
                    save_pend = 1'b1;
                    mem_req_valid = 1'b1;
                    mem_req.addr = {req_q.addr[core_addr_w-1:off_w], {beat_w{1'b0}}};
                end
            end
            ic_miss: begin
                mem_rsp_ready = 1'b1;
                if (issue_cnt != (beat_w + 1)'(transfers_per_line)) begin
                    mem_req_valid = 1'b1;
                    mem_req.addr = {pend_q.addr[core_addr_w-1:off_w], issue_cnt[beat_w-1:0]};
                end
            end
            default: ;
        endcase
    end

endmodule

/* src/main_mem.sv */
`timescale 1ns/1ps

module main_mem
    import icache_cfg_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp
);
    logic [mem_data_w-1:0] mem_arr [2**mem_addr_w];

    logic     q_valid;
    logic     q_ready;
    mem_req_t q_req;
    logic     rd_valid;
    logic     rd_ready;
    mem_rsp_t rd_data;

    initial begin
        $readmemh("mem_init.hex", mem_arr);
    end

    rv_fifo #(
        .payload_t(mem_req_t),
        .depth    (mem_queue_depth)
    ) req_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (req_valid),
        .in_ready (req_ready),
        .in_data  (req),
        .out_valid(q_valid),
        .out_ready(q_ready),
        .out_data (q_req)
    );

    // read stage advances when empty or when its beat moves on
    assign q_ready = !rd_valid || rd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else if (q_ready) begin
            rd_valid <= q_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            rd_data.data <= mem_arr[q_req.addr];
        end
    end

    rv_fifo #(
        .payload_t(mem_rsp_t),
        .depth    (mem_queue_depth)
    ) rsp_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (rd_valid),
        .in_ready (rd_ready),
        .in_data  (rd_data),
        .out_valid(rsp_valid),
        .out_ready(rsp_ready),
        .out_data (rsp)
    );

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_core_valid,
    output logic      req_core_ready,
    input  core_req_t req_core,
    output logic      rsp_core_valid,
    output core_rsp_t rsp_core
);
    // memory channels stay internal
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_req_t mem_req;
    logic     mem_rsp_valid;
    logic     mem_rsp_ready;
    mem_rsp_t mem_rsp;

    icache icache_i (
        .clk           (clk),
        .rst           (rst),
        .req_core_valid(req_core_valid),
        .req_core_ready(req_core_ready),
        .req_core      (req_core),
        .rsp_core_valid(rsp_core_valid),
        .rsp_core      (rsp_core),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp)
    );

    main_mem main_mem_i (
        .clk      (clk),
        .rst      (rst),
        .req_valid(mem_req_valid),
        .req_ready(mem_req_ready),
        .req      (mem_req),
        .rsp_valid(mem_rsp_valid),
        .rsp_ready(mem_rsp_ready),
        .rsp      (mem_rsp)
    );

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

    // reset drops on a rising edge like the rest of the stimulus
    initial begin
        rst <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tests/icache_sva.sv */
`timescale 1ns/1ps

module icache_sva
    import icache_cfg_pkg::*;
    import mem_bus_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input icache_state_t state_q,
    input logic          req_core_ready,
    input logic          rsp_core_valid,
    input logic          mem_req_valid,
    input logic          mem_req_ready,
    input mem_req_t      mem_req
);
    // failures seen so far for the closing line of the run
    int fail_count = 0;

    no_rsp_in_miss: assert property (@(posedge clk) disable iff (rst)
        (state_q == ic_miss) |-> !rsp_core_valid)
        else begin
            fail_count = fail_count + 1;
            $error("rsp_core_valid high while a miss is in progress");
        end

    no_accept_in_miss: assert property (@(posedge clk) disable iff (rst)
        (state_q == ic_miss) |-> !req_core_ready)
        else begin
            fail_count = fail_count + 1;
            $error("req_core_ready high while a miss is in progress");
        end

    // a stalled memory request must not change or vanish
    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else begin
            fail_count = fail_count + 1;
            $error("mem_req changed while waiting for mem_req_ready");
        end

endmodule

bind icache icache_sva icache_sva_i (
    .clk           (clk),
    .rst           (rst),
    .state_q       (state_q),
    .req_core_ready(req_core_ready),
    .rsp_core_valid(rsp_core_valid),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req)
);

/* tests/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import icache_cfg_pkg::*;
    import mem_bus_pkg::*;
();
    localparam int reset_cycles = 4;
    localparam int fetch_limit = 32;
    localparam int stream_len = 8;
    localparam int random_count = 40;
    // fetches issued by all tests together
    localparam int fetch_count = 2 + stream_len + 6 + random_count;
    localparam int timeout_cycles = reset_cycles + 16 + fetch_count * (2 * fetch_limit + 2);
    localparam int word_sel_w = $clog2(mem_data_w / inst_width);

    // lines of the cold miss test sit in set 1 and the lru lines in set 0
    localparam logic [core_addr_w-1:0] first_addr = 7'h1a;
    localparam logic [core_addr_w-1:0] second_addr = 7'h14;
    localparam logic [core_addr_w-1:0] line_a = 7'h03;
    localparam logic [core_addr_w-1:0] line_b = 7'h25;
    localparam logic [core_addr_w-1:0] line_c = 7'h47;

    logic      clk;
    logic      rst;
    logic      req_core_valid;
    logic      req_core_ready;
    core_req_t req_core;
    logic      rsp_core_valid;
    core_rsp_t rsp_core;

    logic [mem_data_w-1:0]  ref_mem [2**mem_addr_w];
    logic [core_addr_w-1:0] stream_addr [stream_len];
    logic [15:0]            lfsr_state = 16'd84;
    int                     checks = 0;
    int                     errors = 0;
    int                     cycle_count = 0;
    int                     sva_fails;

    clk_gen #(
        .period_ns   (100),
        .reset_cycles(reset_cycles)
    ) clk_gen_i (
        .clk(clk),
        .rst(rst)
    );

    icache_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .req_core_valid(req_core_valid),
        .req_core_ready(req_core_ready),
        .req_core      (req_core),
        .rsp_core_valid(rsp_core_valid),
        .rsp_core      (rsp_core)
    );

    // word w of a 128-bit memory word sits at bits 32*w upward
    function automatic core_rsp_t predict_inst(input logic [core_addr_w-1:0] addr);
        core_rsp_t             r;
        logic [mem_data_w-1:0] beat;
        int                    sel;
        beat = ref_mem[addr[core_addr_w-1:word_sel_w]];
        sel = int'(addr[word_sel_w-1:0]);
        r.data = beat[sel*inst_width +: inst_width];
        return r;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    task automatic next_rand_addr(output logic [core_addr_w-1:0] addr);
        int b;
        addr = '0;
        for (b = 0; b < core_addr_w; b++) begin
            addr = {addr[core_addr_w-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_core_rsp(input string name, input core_rsp_t got, input core_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got.data, exp.data);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED %s: got %0h cycles, expected %0h", name, got, exp);
        end
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // latency counts cycles from the accepting edge to the response
    task automatic fetch(input logic [core_addr_w-1:0] addr, output core_rsp_t rsp,
                         output int latency);
        core_req_t req;
        int        waited;
        logic      accepted;
        req.addr = addr;
        rsp = '0;
        latency = 0;
        waited = 0;
        accepted = 1'b0;
        @(posedge clk);
        req_core_valid <= 1'b1;
        req_core <= req;
        while (!accepted && waited < fetch_limit) begin
            @(negedge clk);
            accepted = req_core_ready;
            @(posedge clk);
            waited++;
        end
        req_core_valid <= 1'b0;
        if (!accepted) begin
            errors++;
            $display("request for address %h not accepted within %0d cycles", addr, fetch_limit);
        end else begin
            do begin
                @(negedge clk);
                latency++;
            end while (!rsp_core_valid && latency < fetch_limit);
            if (rsp_core_valid) begin
                rsp = rsp_core;
            end else begin
                errors++;
                $display("no response for address %h within %0d cycles", addr, fetch_limit);
            end
        end
    endtask

    task automatic reset_state();
        int waited;
        waited = 0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        // first cycle out of reset is still ic_reset
        expect_level("rsp_core_valid", rsp_core_valid, 1'b0);
        expect_level("mem_req_valid", dut_i.mem_req_valid, 1'b0);
        expect_level("req_core_ready", req_core_ready, 1'b0);
        while (!req_core_ready && waited < fetch_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!req_core_ready) begin
            errors++;
            $display("req_core_ready never rose after reset");
        end
    endtask

    task automatic cold_miss_fetch();
        core_rsp_t rsp;
        int        latency;
        fetch(first_addr, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(first_addr));
        if (latency <= 1) begin
            errors++;
            $display("first access to an empty line was answered like a hit");
        end
    endtask

    task automatic same_line_hit();
        core_rsp_t rsp;
        int        latency;
        fetch(second_addr, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(second_addr));
        check_latency("rsp_core_valid latency", latency, 1);
    endtask

    // one request per cycle into the filled line with responses following in order
    task automatic streamed_hits();
        int i;
        stream_addr = '{7'h10, 7'h15, 7'h19, 7'h1f, 7'h12, 7'h12, 7'h1c, 7'h17};
        @(posedge clk);
        req_core_valid <= 1'b1;
        req_core.addr <= stream_addr[0];
        for (i = 0; i <= stream_len; i++) begin
            @(negedge clk);
            if (i > 0) begin
                if (!rsp_core_valid) begin
                    errors++;
                    $display("streamed request %0d got no response in the next cycle", i - 1);
                end else begin
                    check_core_rsp("rsp_core", rsp_core, predict_inst(stream_addr[i-1]));
                end
            end
            if (i < stream_len) begin
                if (!req_core_ready) begin
                    errors++;
                    $display("cache stalled during streamed hits at request %0d", i);
                end
                @(posedge clk);
                if (i + 1 < stream_len) begin
                    req_core.addr <= stream_addr[i+1];
                end else begin
                    req_core_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic lru_replacement();
        core_rsp_t rsp;
        int        latency;
        fetch(line_a, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(line_a));
        fetch(line_b, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(line_b));
        fetch(line_a, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(line_a));
        check_latency("rsp_core_valid latency", latency, 1);
        // c replaces b as the least recently used line of the set
        fetch(line_c, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(line_c));
        fetch(line_a, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(line_a));
        check_latency("rsp_core_valid latency", latency, 1);
        fetch(line_b, rsp, latency);
        check_core_rsp("rsp_core", rsp, predict_inst(line_b));
        if (latency <= 1) begin
            errors++;
            $display("line B still hit after line C should have replaced it");
        end
    endtask

    task automatic random_fetches();
        logic [core_addr_w-1:0] addr;
        core_rsp_t              rsp;
        int                     latency;
        int                     i;
        for (i = 0; i < random_count; i++) begin
            next_rand_addr(addr);
            fetch(addr, rsp, latency);
            check_core_rsp("rsp_core", rsp, predict_inst(addr));
        end
    endtask

    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        req_core_valid <= 1'b0;
        req_core <= '0;
        $readmemh("mem_init.hex", ref_mem);
        reset_state();
        cold_miss_fetch();
        same_line_hit();
        streamed_hits();
        lru_replacement();
        random_fetches();
        sva_fails = dut_i.icache_i.icache_sva_i.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* files.f */
src/icache_cfg_pkg.sv
src/mem_bus_pkg.sv
src/rv_fifo.sv
src/icache_way_select.sv
src/icache.sv
src/main_mem.sv
src/icache_top.sv
tests/clk_gen.sv
tests/icache_sva.sv
tests/icache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the icache testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module icache_tb -f files.f -o icache_sim \
    && ./obj_dir/icache_sim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "All tests passed" \
    && echo "PASS" || { echo "FAIL"; exit 1; }

/* mem_init.hex */
// one 128-bit memory word per line, memory word address 0 first
// each 32-bit field is e0 aa 5b aa with aa the core word address, highest address leftmost
e0035b03e0025b02e0015b01e0005b00
e0075b07e0065b06e0055b05e0045b04
e00b5b0be00a5b0ae0095b09e0085b08
e00f5b0fe00e5b0ee00d5b0de00c5b0c
e0135b13e0125b12e0115b11e0105b10
e0175b17e0165b16e0155b15e0145b14
e01b5b1be01a5b1ae0195b19e0185b18
e01f5b1fe01e5b1ee01d5b1de01c5b1c
e0235b23e0225b22e0215b21e0205b20
e0275b27e0265b26e0255b25e0245b24
e02b5b2be02a5b2ae0295b29e0285b28
e02f5b2fe02e5b2ee02d5b2de02c5b2c
e0335b33e0325b32e0315b31e0305b30
e0375b37e0365b36e0355b35e0345b34
e03b5b3be03a5b3ae0395b39e0385b38
e03f5b3fe03e5b3ee03d5b3de03c5b3c
e0435b43e0425b42e0415b41e0405b40
e0475b47e0465b46e0455b45e0445b44
e04b5b4be04a5b4ae0495b49e0485b48
e04f5b4fe04e5b4ee04d5b4de04c5b4c
e0535b53e0525b52e0515b51e0505b50
e0575b57e0565b56e0555b55e0545b54
e05b5b5be05a5b5ae0595b59e0585b58
e05f5b5fe05e5b5ee05d5b5de05c5b5c
e0635b63e0625b62e0615b61e0605b60
e0675b67e0665b66e0655b65e0645b64
e06b5b6be06a5b6ae0695b69e0685b68
e06f5b6fe06e5b6ee06d5b6de06c5b6c
e0735b73e0725b72e0715b71e0705b70
e0775b77e0765b76e0755b75e0745b74
e07b5b7be07a5b7ae0795b79e0785b78
e07f5b7fe07e5b7ee07d5b7de07c5b7c
